// File: ntm_logistic_ifs.sv
/*
 * NTM logistic interfaces
 * Start/ready request buses for arithmetic servers and the scalar unit
 */

`timescale 1ns/10ps
`include "ntm_logistic_macros.svh"

// Two-operand modular request
interface ntm_arith_if;
  logic                      start;
  logic                      ready;
  logic [`NTM_DATA_SIZE-1:0] operand_a;
  logic [`NTM_DATA_SIZE-1:0] operand_b;
  logic [`NTM_DATA_SIZE-1:0] modulo;
  logic [`NTM_DATA_SIZE-1:0] result;

  modport requester (output start, operand_a, operand_b, modulo, input ready, result);
  modport server (input start, operand_a, operand_b, modulo, output ready, result);
endinterface

// One element through the logistic
interface ntm_scalar_if;
  logic                      start;
  logic                      ready;
  logic [`NTM_DATA_SIZE-1:0] modulo;
  logic [`NTM_DATA_SIZE-1:0] data_in;
  logic [`NTM_DATA_SIZE-1:0] data_out;

  modport requester (output start, modulo, data_in, input ready, data_out);
  modport server (input start, modulo, data_in, output ready, data_out);
endinterface

// File: ntm_logistic_macros.svh
/*
 * NTM logistic unit parameters
 * Word widths and the fixed base of the modular exponential
 */

`ifndef NTM_LOGISTIC_MACROS_SVH
`define NTM_LOGISTIC_MACROS_SVH

// Width of every data word and modulus
`define NTM_DATA_SIZE 16

// Base G standing in for e
`define NTM_LOGISTIC_BASE 3

// Element counter and vector length width
`define NTM_INDEX_SIZE 8

`endif

// File: ntm_logistic_pkg.sv
/*
 * NTM logistic package
 * FSM state encodings for the arithmetic blocks and controllers
 */

package ntm_logistic_pkg;

  // Shift-add multiplier
  typedef enum logic {
    MUL_IDLE,
    MUL_ACCUM
  } mul_state_t;

  // Square-and-multiply exponentiator
  typedef enum logic [1:0] {
    EXP_IDLE,
    EXP_SQUARE,
    EXP_MULTIPLY,
    EXP_DONE
  } exp_state_t;

  // Scalar logistic sequencer
  typedef enum logic [1:0] {
    LOG_IDLE,
    LOG_EXP_BASE,
    LOG_INVERT,
    LOG_PRODUCT
  } logistic_state_t;

  // Vector controller, three steps
  typedef enum logic [1:0] {
    VEC_STARTER,
    VEC_INPUT,
    VEC_ENDER
  } vector_state_t;

endpackage

// File: ntm_logistic_top.sv
/*
 * NTM logistic top level
 * Vector controller joined to one scalar logistic unit
 */

`timescale 1ns/10ps
`include "ntm_logistic_macros.svh"

module ntm_logistic_top (
  input  logic                      CLK,
  input  logic                      RST,
  input  logic                      START,
  input  logic                      DATA_IN_ENABLE,
  input  logic [`NTM_DATA_SIZE-1:0]  MODULO_IN,
  input  logic [`NTM_DATA_SIZE-1:0]  DATA_IN,
  input  logic [`NTM_INDEX_SIZE-1:0] SIZE_IN,
  output logic                      READY,
  output logic                      DATA_OUT_ENABLE,
  output logic [`NTM_DATA_SIZE-1:0]  DATA_OUT
);

  // Controller to scalar unit
  ntm_scalar_if scalar_bus ();

  ////////////////////////////////////////
  // Vector controller

  ntm_vector_logistic_function i_vector (
    .CLK             (CLK),
    .RST             (RST),
    .START           (START),
    .DATA_IN_ENABLE  (DATA_IN_ENABLE),
    .MODULO_IN       (MODULO_IN),
    .DATA_IN         (DATA_IN),
    .SIZE_IN         (SIZE_IN),
    .READY           (READY),
    .DATA_OUT_ENABLE (DATA_OUT_ENABLE),
    .DATA_OUT        (DATA_OUT),
    .scalar          (scalar_bus)
  );

  ////////////////////////////////////////
  // Scalar logistic

  ntm_scalar_logistic_function i_scalar (
    .CLK    (CLK),
    .RST    (RST),
    .scalar (scalar_bus)
  );

endmodule

// File: ntm_modular_exponentiator.sv
/*
 * NTM modular exponentiator
 * Left-to-right square-and-multiply, base^exp mod p
 */

`timescale 1ns/10ps
`include "ntm_logistic_macros.svh"

module ntm_modular_exponentiator (
  input logic         CLK,
  input logic         RST,
  ntm_arith_if.server arith
);
  import ntm_logistic_pkg::*;

  localparam int DW = `NTM_DATA_SIZE;
  localparam int CW = $clog2(DW + 1);

  exp_state_t    state_q;
  logic          pending_q;
  logic [CW-1:0] bits_q;
  logic [CW-1:0] top_bits;
  logic          step_done;
  logic [DW-1:0] acc_q;
  logic [DW-1:0] base_q;
  logic [DW-1:0] exp_q;
  logic [DW-1:0] mod_q;

  ntm_arith_if mul_if ();

  ntm_modular_multiplier i_mul (
    .CLK   (CLK),
    .RST   (RST),
    .arith (mul_if)
  );

  // Significant bits of the exponent
  always_comb begin
    top_bits = '0;
    for (int i = 0; i < DW; i++) begin
      if (arith.operand_b[i]) top_bits = CW'(i + 1);
    end
  end

  // Square or multiply of the current bit done
  assign step_done = mul_if.ready && (state_q == EXP_MULTIPLY || !exp_q[DW-1]);

  // Acc stays below p, base may not
  assign mul_if.operand_a = acc_q;
  assign mul_if.operand_b = (state_q == EXP_MULTIPLY) ? base_q : acc_q;
  assign mul_if.modulo    = mod_q;
  assign arith.result     = acc_q;

  always_ff @(posedge CLK) begin
    if (state_q == EXP_IDLE && arith.start) begin
      acc_q  <= DW'(1);
      base_q <= arith.operand_a;
      // Leading zeros shifted out
      exp_q  <= arith.operand_b << (CW'(DW) - top_bits);
      mod_q  <= arith.modulo;
    end else if (mul_if.ready) begin
      acc_q <= mul_if.result;
      if (step_done) exp_q <= exp_q << 1;
    end
  end

  ////////////////////////////////////////
  // Control

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state_q      <= EXP_IDLE;
      pending_q    <= 1'b0;
      bits_q       <= '0;
      mul_if.start <= 1'b0;
      arith.ready  <= 1'b0;
    end else begin
      mul_if.start <= 1'b0;
      arith.ready  <= 1'b0;
      case (state_q)
        EXP_IDLE: begin
          if (arith.start) begin
            pending_q <= 1'b0;
            bits_q    <= top_bits;
            // Zero exponent gives 1 directly
            state_q   <= (top_bits == '0) ? EXP_DONE : EXP_SQUARE;
          end
        end
        EXP_SQUARE, EXP_MULTIPLY: begin
          if (!pending_q) begin
            mul_if.start <= 1'b1;
            pending_q    <= 1'b1;
          end else if (mul_if.ready) begin
            pending_q <= 1'b0;
            if (!step_done) begin
              state_q <= EXP_MULTIPLY;
            end else begin
              bits_q  <= bits_q - CW'(1);
              state_q <= (bits_q == CW'(1)) ? EXP_DONE : EXP_SQUARE;
            end
          end
        end
        EXP_DONE: begin
          arith.ready <= 1'b1;
          state_q     <= EXP_IDLE;
        end
        default: state_q <= EXP_IDLE;
      endcase
    end
  end

  // Multiplier answers only what was asked
  a_mul_ready_pending: assert property (@(posedge CLK) disable iff (RST)
    mul_if.ready |-> pending_q);

endmodule

// File: ntm_modular_multiplier.sv
/*
 * NTM modular multiplier
 * Interleaved shift-add product a * b mod p, one bit of b per cycle
 */

`timescale 1ns/10ps
`include "ntm_logistic_macros.svh"

module ntm_modular_multiplier (
  input logic         CLK,
  input logic         RST,
  ntm_arith_if.server arith
);
  import ntm_logistic_pkg::*;

  localparam int DW = `NTM_DATA_SIZE;
  localparam int CW = $clog2(DW);

  mul_state_t    state_q;
  logic [CW-1:0] bit_cnt_q;
  logic [DW-1:0] acc_q;
  logic [DW-1:0] a_q;
  logic [DW-1:0] b_q;
  logic [DW-1:0] mod_q;
  logic [DW:0]   dbl;
  logic [DW:0]   dbl_red;
  logic [DW:0]   sum;
  logic [DW:0]   sum_red;

  ////////////////////////////////////////
  // Datapath

  // Double, reduce, add a on a set bit, reduce again
  always_comb begin
    dbl     = {acc_q, 1'b0};
    dbl_red = (dbl >= {1'b0, mod_q}) ? dbl - {1'b0, mod_q} : dbl;
    sum     = dbl_red + (b_q[DW-1] ? {1'b0, a_q} : '0);
    sum_red = (sum >= {1'b0, mod_q}) ? sum - {1'b0, mod_q} : sum;
  end

  always_ff @(posedge CLK) begin
    if (state_q == MUL_IDLE && arith.start) begin
      a_q   <= arith.operand_a;
      b_q   <= arith.operand_b;
      mod_q <= arith.modulo;
      acc_q <= '0;
    end else if (state_q == MUL_ACCUM) begin
      acc_q <= sum_red[DW-1:0];
      // Next bit of b into the MSB
      b_q   <= {b_q[DW-2:0], 1'b0};
    end
  end

  assign arith.result = acc_q;

  ////////////////////////////////////////
  // Control, DW bits then ready

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state_q     <= MUL_IDLE;
      bit_cnt_q   <= '0;
      arith.ready <= 1'b0;
    end else begin
      arith.ready <= 1'b0;
      case (state_q)
        MUL_IDLE: begin
          if (arith.start) begin
            bit_cnt_q <= CW'(DW - 1);
            state_q   <= MUL_ACCUM;
          end
        end
        MUL_ACCUM: begin
          bit_cnt_q <= bit_cnt_q - CW'(1);
          // Last bit folded in this cycle
          if (bit_cnt_q == '0) begin
            arith.ready <= 1'b1;
            state_q     <= MUL_IDLE;
          end
        end
        default: state_q <= MUL_IDLE;
      endcase
    end
  end

  // Zero modulus from the requester
  a_mod_nonzero: assert property (@(posedge CLK) disable iff (RST)
    arith.start |-> arith.modulo != '0);

  // Fully reduced product
  a_result_reduced: assert property (@(posedge CLK) disable iff (RST)
    arith.ready |-> acc_q < mod_q);

endmodule

// File: ntm_scalar_logistic_function.sv
/*
 * NTM scalar logistic
 * y = a * (a + 1)^(p-2) mod p with a = G^x mod p
 */

`timescale 1ns/10ps
`include "ntm_logistic_macros.svh"

module ntm_scalar_logistic_function (
  input logic          CLK,
  input logic          RST,
  ntm_scalar_if.server scalar
);
  import ntm_logistic_pkg::*;

  localparam int DW = `NTM_DATA_SIZE;
  localparam logic [DW-1:0] BASE = DW'(`NTM_LOGISTIC_BASE);

  logistic_state_t state_q;
  logic            pending_q;
  logic [DW-1:0]   x_q;
  logic [DW-1:0]   mod_q;
  logic [DW-1:0]   a_q;
  logic [DW-1:0]   inv_q;
  logic [DW-1:0]   y_q;
  logic [DW-1:0]   a_inc;
  logic [DW-1:0]   s_val;

  ntm_arith_if exp_if ();
  ntm_arith_if mul_if ();

  ntm_modular_exponentiator i_exp (
    .CLK   (CLK),
    .RST   (RST),
    .arith (exp_if)
  );

  ntm_modular_multiplier i_mul (
    .CLK   (CLK),
    .RST   (RST),
    .arith (mul_if)
  );

  ////////////////////////////////////////
  // Operand selection

  // s = (a + 1) mod p, a already below p
  assign a_inc = a_q + DW'(1);
  assign s_val = (a_inc == mod_q) ? '0 : a_inc;

  // G^x first, then Fermat inverse s^(p-2)
  assign exp_if.operand_a = (state_q == LOG_INVERT) ? s_val : BASE;
  assign exp_if.operand_b = (state_q == LOG_INVERT) ? mod_q - DW'(2) : x_q;
  assign exp_if.modulo    = mod_q;

  assign mul_if.operand_a = a_q;
  assign mul_if.operand_b = inv_q;
  assign mul_if.modulo    = mod_q;

  assign scalar.data_out = y_q;

  always_ff @(posedge CLK) begin
    if (state_q == LOG_IDLE && scalar.start) begin
      x_q   <= scalar.data_in;
      mod_q <= scalar.modulo;
    end
    if (state_q == LOG_EXP_BASE && exp_if.ready) a_q <= exp_if.result;
    if (state_q == LOG_INVERT && exp_if.ready) inv_q <= exp_if.result;
    if (mul_if.ready) y_q <= mul_if.result;
  end

  ////////////////////////////////////////
  // Sequencer, one request at a time

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state_q      <= LOG_IDLE;
      pending_q    <= 1'b0;
      exp_if.start <= 1'b0;
      mul_if.start <= 1'b0;
      scalar.ready <= 1'b0;
    end else begin
      exp_if.start <= 1'b0;
      mul_if.start <= 1'b0;
      scalar.ready <= 1'b0;
      case (state_q)
        LOG_IDLE: begin
          if (scalar.start) begin
            pending_q <= 1'b0;
            state_q   <= LOG_EXP_BASE;
          end
        end
        LOG_EXP_BASE, LOG_INVERT: begin
          if (!pending_q) begin
            exp_if.start <= 1'b1;
            pending_q    <= 1'b1;
          end else if (exp_if.ready) begin
            pending_q <= 1'b0;
            state_q   <= (state_q == LOG_EXP_BASE) ? LOG_INVERT : LOG_PRODUCT;
          end
        end
        LOG_PRODUCT: begin
          if (!pending_q) begin
            mul_if.start <= 1'b1;
            pending_q    <= 1'b1;
          end else if (mul_if.ready) begin
            // Result registered in the same edge
            pending_q    <= 1'b0;
            scalar.ready <= 1'b1;
            state_q      <= LOG_IDLE;
          end
        end
        default: state_q <= LOG_IDLE;
      endcase
    end
  end

endmodule

// File: ntm_vector_logistic_function.sv
/*
 * NTM vector logistic controller
 * Feeds SIZE_IN elements one by one through the scalar unit
 */

`timescale 1ns/10ps
`include "ntm_logistic_macros.svh"

module ntm_vector_logistic_function (
  input  logic                      CLK,
  input  logic                      RST,
  input  logic                      START,
  input  logic                      DATA_IN_ENABLE,
  input  logic [`NTM_DATA_SIZE-1:0]  MODULO_IN,
  input  logic [`NTM_DATA_SIZE-1:0]  DATA_IN,
  input  logic [`NTM_INDEX_SIZE-1:0] SIZE_IN,
  output logic                      READY,
  output logic                      DATA_OUT_ENABLE,
  output logic [`NTM_DATA_SIZE-1:0]  DATA_OUT,
  ntm_scalar_if.requester           scalar
);
  import ntm_logistic_pkg::*;

  localparam int IW = `NTM_INDEX_SIZE;

  vector_state_t state_q;
  logic [IW-1:0] index_q;
  logic [IW-1:0] last_idx_q;

  ////////////////////////////////////////
  // Element latch

  always_ff @(posedge CLK) begin
    if (state_q == VEC_INPUT && DATA_IN_ENABLE) begin
      scalar.modulo  <= MODULO_IN;
      scalar.data_in <= DATA_IN;
    end
  end

  ////////////////////////////////////////
  // Three-step controller

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state_q         <= VEC_STARTER;
      index_q         <= '0;
      last_idx_q      <= '0;
      scalar.start    <= 1'b0;
      READY           <= 1'b0;
      DATA_OUT_ENABLE <= 1'b0;
      DATA_OUT        <= '0;
    end else begin
      scalar.start    <= 1'b0;
      READY           <= 1'b0;
      DATA_OUT_ENABLE <= 1'b0;
      case (state_q)
        VEC_STARTER: begin
          if (START) begin
            index_q    <= '0;
            last_idx_q <= SIZE_IN - IW'(1);
            state_q    <= VEC_INPUT;
          end
        end
        VEC_INPUT: begin
          // Every element gets its own scalar request
          if (DATA_IN_ENABLE) begin
            scalar.start <= 1'b1;
            state_q      <= VEC_ENDER;
          end
        end
        VEC_ENDER: begin
          if (scalar.ready) begin
            DATA_OUT        <= scalar.data_out;
            DATA_OUT_ENABLE <= 1'b1;
            if (index_q == last_idx_q) begin
              READY   <= 1'b1;
              state_q <= VEC_STARTER;
            end else begin
              index_q <= index_q + IW'(1);
              state_q <= VEC_INPUT;
            end
          end
        end
        default: state_q <= VEC_STARTER;
      endcase
    end
  end

  // A new vector only once the previous one is finished
  a_start_in_starter: assert property (@(posedge CLK) disable iff (RST)
    START |-> state_q == VEC_STARTER);

endmodule

// File: project.f
+incdir+.
ntm_logistic_pkg.sv
ntm_logistic_ifs.sv
ntm_modular_multiplier.sv
ntm_modular_exponentiator.sv
ntm_scalar_logistic_function.sv
ntm_vector_logistic_function.sv
ntm_logistic_top.sv
tb_ntm_logistic.sv

// File: run.sh
#!/bin/sh
# Build the NTM logistic testbench with Verilator and run it
# The run passes only when the simulation output holds the pass line
verilator --binary --timing --assert -f project.f --top-module tb_ntm_logistic -Mdir obj_dir \
  && ./obj_dir/Vtb_ntm_logistic | tee /dev/stderr | grep -q "TEST RESULT: PASS" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// File: tb_ntm_logistic.sv
/*
 * NTM logistic testbench
 * Table-driven vectors checked against a modular reference model
 */

`timescale 1ns/10ps
`include "ntm_logistic_macros.svh"

module tb_ntm_logistic;

  localparam int DW          = `NTM_DATA_SIZE;
  localparam int IW          = `NTM_INDEX_SIZE;
  localparam int NUM_ENTRIES = 9;
  localparam int MAX_LEN     = 8;
  // Per-element cycle bound and fixed slack
  localparam int ELEM_CYCLES = 4 * DW * DW;
  localparam int MARGIN      = 2000;

  logic          CLK;
  logic          RST;
  logic          START;
  logic          DATA_IN_ENABLE;
  logic [DW-1:0] MODULO_IN;
  logic [DW-1:0] DATA_IN;
  logic [IW-1:0] SIZE_IN;
  logic          READY;
  logic          DATA_OUT_ENABLE;
  logic [DW-1:0] DATA_OUT;

  // Stimulus table, one row per vector
  int tbl_mod   [NUM_ENTRIES];
  int tbl_len   [NUM_ENTRIES];
  bit tbl_rand  [NUM_ENTRIES];
  bit tbl_noise [NUM_ENTRIES];
  int tbl_first [NUM_ENTRIES];
  int tbl_elem  [NUM_ENTRIES][MAX_LEN];

  logic [31:0] lfsr_state = 32'hf207e21e;
  int          limit_cycles = 0;

  ntm_logistic_top i_ntm_logistic_top (
    .CLK             (CLK),
    .RST             (RST),
    .START           (START),
    .DATA_IN_ENABLE  (DATA_IN_ENABLE),
    .MODULO_IN       (MODULO_IN),
    .DATA_IN         (DATA_IN),
    .SIZE_IN         (SIZE_IN),
    .READY           (READY),
    .DATA_OUT_ENABLE (DATA_OUT_ENABLE),
    .DATA_OUT        (DATA_OUT)
  );

  // 10 ns clock
  always #5 CLK = ~CLK;

  ////////////////////////////////////////
  // Reference model and random source

  // Right-to-left binary powering
  function automatic longint powmod(input longint b, input longint e, input longint m);
    longint r;
    longint bb;
    longint ee;
    r  = 1 % m;
    bb = b % m;
    ee = e;
    while (ee > 0) begin
      if (ee % 2 == 1) r = (r * bb) % m;
      bb = (bb * bb) % m;
      ee = ee / 2;
    end
    return r;
  endfunction

  // y = a * (a + 1)^(p-2) with a = G^x and y = 0 when a + 1 wraps to 0
  function automatic longint logistic_model(input longint x, input longint p);
    longint a;
    longint s;
    a = powmod(longint'(`NTM_LOGISTIC_BASE), x, p);
    s = (a + 1) % p;
    return (a * powmod(s, p - 2, p)) % p;
  endfunction

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One LFSR step per bit, then folded below p
  function automatic logic [DW-1:0] random_below(input int p);
    logic [DW-1:0] v;
    v = '0;
    for (int b = 0; b < DW; b++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[DW-2:0], lfsr_state[0]};
    end
    return DW'(int'(v) % p);
  endfunction

  ////////////////////////////////////////
  // Checker and helpers

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("FAILED %s: got 0x%h, expected 0x%h", name, actual, expected);
      $display("TEST RESULT: FAIL");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  // Quiet cycles with no result strobes
  task automatic idle_cycles(input int n, input bit data_zero);
    repeat (n) begin
      @(posedge CLK);
      #1;
      check_value("READY", 32'(READY), 32'd0);
      check_value("DATA_OUT_ENABLE", 32'(DATA_OUT_ENABLE), 32'd0);
      if (data_zero) check_value("DATA_OUT", 32'(DATA_OUT), 32'd0);
    end
  endtask

  task automatic set_entry(input int idx, input int p, input int len, input bit rnd,
                           input bit noise, input int first,
                           input int e0, input int e1, input int e2,
                           input int e3, input int e4);
    tbl_mod[idx]   = p;
    tbl_len[idx]   = len;
    tbl_rand[idx]  = rnd;
    tbl_noise[idx] = noise;
    tbl_first[idx] = first;
    for (int i = 0; i < MAX_LEN; i++) tbl_elem[idx][i] = 0;
    tbl_elem[idx][0] = e0;
    tbl_elem[idx][1] = e1;
    tbl_elem[idx][2] = e2;
    tbl_elem[idx][3] = e3;
    tbl_elem[idx][4] = e4;
  endtask

  // Columns are index, p, length, random, noise, known first result (-1 none), elements
  task automatic load_table();
    set_entry(0, 11,    1, 1'b0, 1'b0,  6, 0, 0, 0, 0, 0);
    set_entry(1, 13,    5, 1'b0, 1'b0, -1, 0, 1, 2, 5, 12);
    // 3 generates mod 7, so x = 3 gives a = -1
    set_entry(2, 7,     1, 1'b0, 1'b0,  0, 3, 0, 0, 0, 0);
    set_entry(3, 7,     3, 1'b0, 1'b0,  0, 3, 0, 6, 0, 0);
    set_entry(4, 251,   6, 1'b1, 1'b0, -1, 0, 0, 0, 0, 0);
    set_entry(5, 8191,  5, 1'b1, 1'b0, -1, 0, 0, 0, 0, 0);
    set_entry(6, 16381, 4, 1'b1, 1'b0, -1, 0, 0, 0, 0, 0);
    set_entry(7, 13,    4, 1'b0, 1'b1, -1, 7, 3, 9, 11, 0);
    set_entry(8, 16381, 1, 1'b0, 1'b1, -1, 100, 0, 0, 0, 0);
  endtask

  ////////////////////////////////////////
  // One vector through the DUT

  task automatic run_entry(input int e);
    int            p;
    int            len;
    int            wait_cycles;
    longint        expected;
    logic [DW-1:0] x;
    logic [DW-1:0] elems [MAX_LEN];
    p   = tbl_mod[e];
    len = tbl_len[e];
    for (int i = 0; i < len; i++) begin
      elems[i] = tbl_rand[e] ? random_below(p) : DW'(tbl_elem[e][i]);
    end
    START     = 1'b1;
    MODULO_IN = DW'(p);
    SIZE_IN   = IW'(len);
    @(posedge CLK);
    #1;
    START = 1'b0;
    for (int i = 0; i < len; i++) begin
      x              = elems[i];
      DATA_IN_ENABLE = 1'b1;
      DATA_IN        = x;
      @(posedge CLK);
      #1;
      DATA_IN_ENABLE = 1'b0;
      wait_cycles    = 0;
      while (DATA_OUT_ENABLE !== 1'b1) begin
        check_value("READY", 32'(READY), 32'd0);
        // Stray enables with a wrong element while busy
        if (tbl_noise[e] && wait_cycles < 4) begin
          DATA_IN_ENABLE = (wait_cycles % 2 == 0);
          DATA_IN        = ~x;
        end else begin
          DATA_IN_ENABLE = 1'b0;
        end
        @(posedge CLK);
        #1;
        wait_cycles++;
      end
      expected = logistic_model(longint'(x), longint'(p));
      check_value("DATA_OUT", 32'(DATA_OUT), 32'(expected));
      if (i == 0 && tbl_first[e] >= 0) begin
        check_value("DATA_OUT", 32'(DATA_OUT), 32'(tbl_first[e]));
      end
      check_value("READY", 32'(READY), 32'(i == len - 1));
    end
    // No extra outputs after the last one
    idle_cycles(4, 1'b0);
  endtask

  ////////////////////////////////////////
  // Main sequence and watchdog

  initial begin : main_sequence
    int total;
    CLK            = 1'b0;
    RST            = 1'b1;
    START          = 1'b0;
    DATA_IN_ENABLE = 1'b0;
    MODULO_IN      = '0;
    DATA_IN        = '0;
    SIZE_IN        = '0;
    load_table();
    total = 0;
    for (int e = 0; e < NUM_ENTRIES; e++) total += tbl_len[e];
    limit_cycles = total * ELEM_CYCLES + NUM_ENTRIES * 16 + MARGIN;
    repeat (2) @(posedge CLK);
    #1;
    RST = 1'b0;
    // Outputs quiet before any START
    idle_cycles(6, 1'b1);
    for (int e = 0; e < NUM_ENTRIES; e++) run_entry(e);
    $display("TEST RESULT: PASS");
    $finish;
  end

  initial begin : watchdog
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge CLK);
    $display("Timeout: the vectors did not finish within %0d cycles", limit_cycles);
    $display("TEST RESULT: FAIL");
    $fatal(1, "watchdog expired");
  end

endmodule
